/* include/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data word width of the integer datapath
`define RV_XLEN 32

// Register index width, five bits for x0 to x31
`define RV_REG_IDX_W 5

// Architectural register count
`define RV_NREGS 32

`endif

/* hw/rv_pkg.sv */
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]      word_t;      // Data word or address
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;   // Register index
  typedef logic [2:0]               alu_class_t; // ALU operation class
  typedef logic [2:0]               funct3_t;    // Minor opcode

  // ALU operation classes in ALU op select order
  localparam alu_class_t ALU_MEM    = 3'd0; // Load and store address
  localparam alu_class_t ALU_BRANCH = 3'd1; // Conditional branches
  localparam alu_class_t ALU_REG    = 3'd2; // Register-register ops
  localparam alu_class_t ALU_IMM    = 3'd3; // Register-immediate ops
  localparam alu_class_t ALU_LUI    = 3'd4;
  localparam alu_class_t ALU_AUIPC  = 3'd5;
  localparam alu_class_t ALU_JAL    = 3'd6;
  localparam alu_class_t ALU_JALR   = 3'd7;

  // Major opcodes in instruction bits [6:0]
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Arithmetic funct3 codes
  localparam funct3_t F3_ADD  = 3'd0; // ADD or SUB
  localparam funct3_t F3_SLL  = 3'd1;
  localparam funct3_t F3_SLT  = 3'd2;
  localparam funct3_t F3_SLTU = 3'd3;
  localparam funct3_t F3_XOR  = 3'd4;
  localparam funct3_t F3_SR   = 3'd5; // SRL or SRA
  localparam funct3_t F3_OR   = 3'd6;
  localparam funct3_t F3_AND  = 3'd7;

endpackage

`default_nettype wire

/* hw/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_decode (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  rv_pkg::word_t      i_instr,
  input  rv_pkg::word_t      i_pc,
  output logic               o_valid,
  output rv_pkg::word_t      o_pc,
  output rv_pkg::reg_idx_t   o_rs1,
  output rv_pkg::reg_idx_t   o_rs2,
  output rv_pkg::reg_idx_t   o_rd,
  output rv_pkg::alu_class_t o_alu_class,
  output rv_pkg::funct3_t    o_funct3,
  output logic               o_funct7,
  output rv_pkg::word_t      o_imm,
  output logic               o_wr_en
);

  import rv_pkg::*;

  logic [6:0] opcode;     // Major opcode
  funct3_t    funct3;
  reg_idx_t   rd;
  word_t      imm_i;      // Loads, JALR, ALU immediates
  word_t      imm_s;      // Stores
  word_t      imm_b;      // Branches, even offset
  word_t      imm_u;      // LUI, AUIPC
  word_t      imm_j;      // JAL, even offset
  alu_class_t dec_class;
  word_t      dec_imm;
  logic       dec_funct7; // Selects SUB and SRA
  logic       dec_writes; // Class writes rd

  assign opcode = i_instr[6:0];
  assign funct3 = i_instr[14:12];
  assign rd     = i_instr[11:7];

  assign imm_i = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{(`RV_XLEN-12){i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{(`RV_XLEN-13){i_instr[31]}}, i_instr[31], i_instr[7],
                  i_instr[30:25], i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){i_instr[31]}}, i_instr[31], i_instr[19:12],
                  i_instr[20], i_instr[30:21], 1'b0};

  always_comb
  begin
    dec_class  = ALU_MEM; // Unknown opcodes fall back here with no write
    dec_imm    = imm_i;
    dec_funct7 = 1'b0;
    dec_writes = 1'b0;
    case (opcode)
      OPC_LOAD:
      begin
        dec_writes = 1'b1;
      end
      OPC_STORE:
      begin
        dec_imm = imm_s; // Address only, no write
      end
      OPC_BRANCH:
      begin
        dec_class = ALU_BRANCH;
        dec_imm   = imm_b;
      end
      OPC_OP:
      begin
        dec_class  = ALU_REG;
        dec_funct7 = i_instr[30];
        dec_writes = 1'b1;
      end
      OPC_OP_IMM:
      begin
        dec_class  = ALU_IMM;
        dec_funct7 = (funct3 == F3_SLL || funct3 == F3_SR) ? i_instr[30] : 1'b0; // Shifts only
        dec_writes = 1'b1;
      end
      OPC_LUI:
      begin
        dec_class  = ALU_LUI;
        dec_imm    = imm_u;
        dec_writes = 1'b1;
      end
      OPC_AUIPC:
      begin
        dec_class  = ALU_AUIPC;
        dec_imm    = imm_u;
        dec_writes = 1'b1;
      end
      OPC_JAL:
      begin
        dec_class  = ALU_JAL;
        dec_imm    = imm_j;
        dec_writes = 1'b1;
      end
      OPC_JALR:
      begin
        dec_class  = ALU_JALR;
        dec_writes = 1'b1;
      end
      default:
      begin
        dec_writes = 1'b0;
      end
    endcase
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_valid <= 1'b0;
      o_wr_en <= 1'b0;
    end
    else
    begin
      o_valid <= i_valid;
      o_wr_en <= i_valid & dec_writes & (rd != '0); // x0 writes dropped here
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_pc        <= i_pc;
    o_rs1       <= i_instr[19:15];
    o_rs2       <= i_instr[24:20];
    o_rd        <= rd;
    o_alu_class <= dec_class;
    o_funct3    <= funct3;
    o_funct7    <= dec_funct7;
    o_imm       <= dec_imm;
  end

endmodule

`default_nettype wire

/* hw/rv_operand.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_operand (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  rv_pkg::word_t      i_pc,
  input  rv_pkg::reg_idx_t   i_rs1,
  input  rv_pkg::reg_idx_t   i_rs2,
  input  rv_pkg::reg_idx_t   i_rd,
  input  rv_pkg::alu_class_t i_alu_class,
  input  rv_pkg::funct3_t    i_funct3,
  input  logic               i_funct7,
  input  rv_pkg::word_t      i_imm,
  input  logic               i_wr_en,
  input  logic               i_wb_valid,
  input  logic               i_wb_en,
  input  rv_pkg::reg_idx_t   i_wb_rd,
  input  rv_pkg::word_t      i_wb_data,
  output logic               o_valid,
  output rv_pkg::word_t      o_pc,
  output rv_pkg::reg_idx_t   o_rs1,
  output rv_pkg::reg_idx_t   o_rs2,
  output rv_pkg::reg_idx_t   o_rd,
  output rv_pkg::word_t      o_a,
  output rv_pkg::word_t      o_b,
  output rv_pkg::alu_class_t o_alu_class,
  output rv_pkg::funct3_t    o_funct3,
  output logic               o_funct7,
  output rv_pkg::word_t      o_imm,
  output logic               o_wr_en
);

  import rv_pkg::*;

  word_t regs [`RV_NREGS]; // x0 entry stays zero
  logic  wb_we;            // Qualified write strobe
  word_t rd_a;
  word_t rd_b;

  assign wb_we = i_wb_valid & i_wb_en & (i_wb_rd != '0);

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      for (int i = 0; i < `RV_NREGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb_we)
    begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // Same-cycle write to the read index wins
  assign rd_a = (wb_we && (i_wb_rd == i_rs1)) ? i_wb_data : regs[i_rs1];
  assign rd_b = (wb_we && (i_wb_rd == i_rs2)) ? i_wb_data : regs[i_rs2];

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_valid <= 1'b0;
      o_wr_en <= 1'b0;
    end
    else
    begin
      o_valid <= i_valid;
      o_wr_en <= i_valid & i_wr_en;
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_pc        <= i_pc;
    o_rs1       <= i_rs1; // Indices kept for execute forwarding
    o_rs2       <= i_rs2;
    o_rd        <= i_rd;
    o_a         <= rd_a;
    o_b         <= rd_b;
    o_alu_class <= i_alu_class;
    o_funct3    <= i_funct3;
    o_funct7    <= i_funct7;
    o_imm       <= i_imm;
  end

endmodule

`default_nettype wire

/* hw/rv_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_alu (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  rv_pkg::word_t      i_pc,
  input  rv_pkg::reg_idx_t   i_rs1,
  input  rv_pkg::reg_idx_t   i_rs2,
  input  rv_pkg::reg_idx_t   i_rd,
  input  rv_pkg::word_t      i_a,
  input  rv_pkg::word_t      i_b,
  input  rv_pkg::alu_class_t i_alu_class,
  input  rv_pkg::funct3_t    i_funct3,
  input  logic               i_funct7,
  input  rv_pkg::word_t      i_imm,
  input  logic               i_wr_en,
  output logic               o_valid,
  output rv_pkg::reg_idx_t   o_rd,
  output logic               o_wr_en,
  output rv_pkg::word_t      o_result,
  output logic               o_branch_taken,
  output rv_pkg::word_t      o_target
);

  import rv_pkg::*;

  logic       fwd_ok;   // Held entry wrote a live register
  word_t      op_a;
  word_t      op_b;     // Forwarded rs2 value
  word_t      op_y;     // Second ALU input, rs2 or immediate
  logic [4:0] shamt;
  word_t      pc_imm;   // Branch, JAL and AUIPC target
  word_t      link;     // Return address
  word_t      alu_out;
  word_t      result;
  word_t      target;
  logic       taken;

  assign fwd_ok = o_valid & o_wr_en & (o_rd != '0);
  assign op_a   = (fwd_ok && (o_rd == i_rs1)) ? o_result : i_a;
  assign op_b   = (fwd_ok && (o_rd == i_rs2)) ? o_result : i_b;

  assign op_y   = (i_alu_class == ALU_IMM) ? i_imm : op_b;
  assign shamt  = op_y[4:0]; // Upper bits ignored
  assign pc_imm = i_pc + i_imm;
  assign link   = i_pc + `RV_XLEN'd4;

  always_comb
  begin
    case (i_funct3)
      F3_ADD:  alu_out = i_funct7 ? (op_a - op_y) : (op_a + op_y);
      F3_SLL:  alu_out = op_a << shamt;
      F3_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_y)};
      F3_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_y};
      F3_XOR:  alu_out = op_a ^ op_y;
      F3_SR:   alu_out = i_funct7 ? word_t'($signed(op_a) >>> shamt) : (op_a >> shamt);
      F3_OR:   alu_out = op_a | op_y;
      default: alu_out = op_a & op_y; // AND
    endcase
  end

  always_comb
  begin
    case (i_funct3)
      3'd0:    taken = (op_a == op_b);                  // BEQ
      3'd1:    taken = (op_a != op_b);                  // BNE
      3'd4:    taken = ($signed(op_a) <  $signed(op_b)); // BLT
      3'd5:    taken = ($signed(op_a) >= $signed(op_b)); // BGE
      3'd6:    taken = (op_a <  op_b);                  // BLTU
      3'd7:    taken = (op_a >= op_b);                  // BGEU
      default: taken = 1'b0;                            // Reserved codes
    endcase
  end

  always_comb
  begin
    target = pc_imm;
    case (i_alu_class)
      ALU_MEM:    result = op_a + i_imm; // Load or store address
      ALU_BRANCH: result = pc_imm;
      ALU_REG:    result = alu_out;
      ALU_IMM:    result = alu_out;
      ALU_LUI:    result = i_imm;
      ALU_AUIPC:  result = pc_imm;
      ALU_JAL:    result = link;
      default:
      begin
        result = link; // JALR
        target = (op_a + i_imm) & ~`RV_XLEN'd1;
      end
    endcase
  end

  always_ff @(posedge i_clk)
  begin
    if (i_rst)
    begin
      o_valid        <= 1'b0;
      o_wr_en        <= 1'b0;
      o_branch_taken <= 1'b0;
    end
    else
    begin
      o_valid        <= i_valid;
      o_wr_en        <= i_valid & i_wr_en;
      case (i_alu_class)
        ALU_BRANCH: o_branch_taken <= i_valid & taken;
        ALU_JAL:    o_branch_taken <= i_valid; // Jumps always taken
        ALU_JALR:   o_branch_taken <= i_valid;
        default:    o_branch_taken <= 1'b0;
      endcase
    end
  end

  always_ff @(posedge i_clk)
  begin
    o_rd     <= i_rd;
    o_result <= result;
    o_target <= target;
  end

endmodule

`default_nettype wire

/* hw/rv_exec_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_core (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_valid,
  input  rv_pkg::word_t    i_instr,
  input  rv_pkg::word_t    i_pc,
  output logic             o_valid,
  output rv_pkg::reg_idx_t o_rd,
  output logic             o_wr_en,
  output rv_pkg::word_t    o_result,
  output logic             o_branch_taken,
  output rv_pkg::word_t    o_target
);

  import rv_pkg::*;

  // Decode to operand stage
  logic       dec_valid;
  word_t      dec_pc;
  reg_idx_t   dec_rs1;
  reg_idx_t   dec_rs2;
  reg_idx_t   dec_rd;
  alu_class_t dec_class;
  funct3_t    dec_funct3;
  logic       dec_funct7;
  word_t      dec_imm;
  logic       dec_wr_en;

  // Operand to execute stage
  logic       opd_valid;
  word_t      opd_pc;
  reg_idx_t   opd_rs1;
  reg_idx_t   opd_rs2;
  reg_idx_t   opd_rd;
  word_t      opd_a;
  word_t      opd_b;
  alu_class_t opd_class;
  funct3_t    opd_funct3;
  logic       opd_funct7;
  word_t      opd_imm;
  logic       opd_wr_en;

  rv_decode u_decode (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_instr     (i_instr),
    .i_pc        (i_pc),
    .o_valid     (dec_valid),
    .o_pc        (dec_pc),
    .o_rs1       (dec_rs1),
    .o_rs2       (dec_rs2),
    .o_rd        (dec_rd),
    .o_alu_class (dec_class),
    .o_funct3    (dec_funct3),
    .o_funct7    (dec_funct7),
    .o_imm       (dec_imm),
    .o_wr_en     (dec_wr_en)
  );

  rv_operand u_operand (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (dec_valid),
    .i_pc        (dec_pc),
    .i_rs1       (dec_rs1),
    .i_rs2       (dec_rs2),
    .i_rd        (dec_rd),
    .i_alu_class (dec_class),
    .i_funct3    (dec_funct3),
    .i_funct7    (dec_funct7),
    .i_imm       (dec_imm),
    .i_wr_en     (dec_wr_en),
    .i_wb_valid  (o_valid),  // Writeback straight from execute outputs
    .i_wb_en     (o_wr_en),
    .i_wb_rd     (o_rd),
    .i_wb_data   (o_result),
    .o_valid     (opd_valid),
    .o_pc        (opd_pc),
    .o_rs1       (opd_rs1),
    .o_rs2       (opd_rs2),
    .o_rd        (opd_rd),
    .o_a         (opd_a),
    .o_b         (opd_b),
    .o_alu_class (opd_class),
    .o_funct3    (opd_funct3),
    .o_funct7    (opd_funct7),
    .o_imm       (opd_imm),
    .o_wr_en     (opd_wr_en)
  );

  rv_alu u_alu (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_valid        (opd_valid),
    .i_pc           (opd_pc),
    .i_rs1          (opd_rs1),
    .i_rs2          (opd_rs2),
    .i_rd           (opd_rd),
    .i_a            (opd_a),
    .i_b            (opd_b),
    .i_alu_class    (opd_class),
    .i_funct3       (opd_funct3),
    .i_funct7       (opd_funct7),
    .i_imm          (opd_imm),
    .i_wr_en        (opd_wr_en),
    .o_valid        (o_valid),
    .o_rd           (o_rd),
    .o_wr_en        (o_wr_en),
    .o_result       (o_result),
    .o_branch_taken (o_branch_taken),
    .o_target       (o_target)
  );

endmodule

`default_nettype wire

/* verif/rv_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_clkgen (
  output logic o_clk,
  output logic o_rst
);

  initial
  begin
    o_clk = 1'b0;
    forever #20 o_clk = ~o_clk; // 40 ns period
  end

  initial
  begin
    o_rst = 1'b1;
    repeat (3) @(posedge o_clk); // Three cycles in reset
    o_rst <= 1'b0;
  end

endmodule

`default_nettype wire

/* verif/rv_exec_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_chk (
  input logic             i_clk,
  input logic             i_rst,
  input logic             i_valid,     // Issue strobe of the core
  input logic             i_out_valid, // Result strobe of the core
  input logic             i_wr_en,
  input rv_pkg::reg_idx_t i_rd,
  input logic             i_taken
);

  int err_cnt = 0; // Failed assertion count

  // Reset clears the result strobe
  a_rst_quiet: assert property (@(posedge i_clk) i_rst |=> !i_out_valid)
    else
    begin
      $error("o_valid high right after a reset cycle");
      err_cnt++;
    end

  a_wr_valid: assert property (@(posedge i_clk) disable iff (i_rst) i_wr_en |-> i_out_valid)
    else
    begin
      $error("o_wr_en high without o_valid");
      err_cnt++;
    end

  a_tk_valid: assert property (@(posedge i_clk) disable iff (i_rst) i_taken |-> i_out_valid)
    else
    begin
      $error("o_branch_taken high without o_valid");
      err_cnt++;
    end

  a_no_x0: assert property (@(posedge i_clk) disable iff (i_rst) i_wr_en |-> (i_rd != '0))
    else
    begin
      $error("write to x0 reached the outputs");
      err_cnt++;
    end

  // Fixed three-stage latency in both polarities
  a_lat_hi: assert property (@(posedge i_clk) disable iff (i_rst) i_valid |-> ##3 i_out_valid)
    else
    begin
      $error("result strobe missing three cycles after issue");
      err_cnt++;
    end

  a_lat_lo: assert property (@(posedge i_clk) disable iff (i_rst) !i_valid |-> ##3 !i_out_valid)
    else
    begin
      $error("result strobe without an issue three cycles earlier");
      err_cnt++;
    end

endmodule

`default_nettype wire

/* verif/rv_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb;

  import rv_pkg::*;

  typedef struct packed {
    word_t    instr;
    word_t    pc;
    logic     wr;      // Expected o_wr_en
    reg_idx_t rd;
    word_t    res;
    logic     chk_res; // Result defined for this class
    logic     tk;
    word_t    tgt;
    logic     chk_tgt; // Target defined for this class
  } entry_t;

  logic     clk;
  logic     rst;
  logic     valid;
  word_t    instr;
  word_t    pc;
  logic     res_valid;
  reg_idx_t res_rd;
  logic     res_wr_en;
  word_t    result;
  logic     taken;
  word_t    target;

  entry_t   tbl [$];      // Stimulus and expected values
  string    tbl_name [$];
  word_t    mregs [0:31]; // Model register file
  word_t    pc_next;      // PC of the next table entry
  word_t    rng;
  int       issue_q [$];  // Negedge count at issue
  int       ncyc;
  int       chk_idx;
  int       pass_cnt;
  int       fail_cnt;
  int       wait_cnt;
  logic     test_bad;
  string    cur_name;

  rv_clkgen u_clkgen (
    .o_clk (clk),
    .o_rst (rst)
  );

  rv_exec_core uut (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_valid        (valid),
    .i_instr        (instr),
    .i_pc           (pc),
    .o_valid        (res_valid),
    .o_rd           (res_rd),
    .o_wr_en        (res_wr_en),
    .o_result       (result),
    .o_branch_taken (taken),
    .o_target       (target)
  );

  bind rv_exec_core rv_exec_chk u_chk (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_valid     (i_valid),
    .i_out_valid (o_valid),
    .i_wr_en     (o_wr_en),
    .i_rd        (o_rd),
    .i_taken     (o_branch_taken)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic word_t sign12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // One encoder per instruction format
  function automatic word_t r_type(input logic alt, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input funct3_t f3, input reg_idx_t rd);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input funct3_t f3, input reg_idx_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_idx_t rs2,
                                   input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], OPC_STORE}; // SW
  endfunction

  function automatic word_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input funct3_t f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t j_type(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // Reference ALU from the ISA rules
  function automatic word_t alu_model(input funct3_t f3, input logic alt,
                                      input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0]; // Only the low five bits shift
    case (f3)
      F3_ADD:  return alt ? (a - b) : (a + b);
      F3_SLL:  return a << sh;
      F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
      F3_XOR:  return a ^ b;
      F3_SR:   return (a >> sh) | ({32{alt & a[31]}} & ~(32'hffff_ffff >> sh)); // Sign fill
      F3_OR:   return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_model(input funct3_t f3, input word_t a, input word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic set_reg(input reg_idx_t rd, input word_t v);
    if (rd != '0)
      mregs[rd] = v; // x0 stays zero
  endtask

  task automatic add_entry(input string name, input word_t ins, input logic wr,
                           input reg_idx_t rd, input word_t res, input logic chk_res,
                           input logic tk, input word_t tgt, input logic chk_tgt);
    entry_t e;
    e.instr   = ins;
    e.pc      = pc_next;
    e.wr      = wr;
    e.rd      = rd;
    e.res     = res;
    e.chk_res = chk_res;
    e.tk      = tk;
    e.tgt     = tgt;
    e.chk_tgt = chk_tgt;
    tbl.push_back(e);
    tbl_name.push_back(name);
    pc_next = pc_next + 32'd4;
  endtask

  task automatic reg_op(input string name, input funct3_t f3, input logic alt,
                        input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
    word_t r;
    r = alu_model(f3, alt, mregs[rs1], mregs[rs2]);
    add_entry(name, r_type(alt, rs2, rs1, f3, rd), rd != '0, rd, r, 1'b1, 1'b0, '0, 1'b0);
    set_reg(rd, r);
  endtask

  task automatic imm_op(input string name, input funct3_t f3, input reg_idx_t rd,
                        input reg_idx_t rs1, input logic [11:0] imm);
    word_t r;
    logic  alt;
    alt = (f3 == F3_SR) ? imm[10] : 1'b0; // SRAI marker bit
    r   = alu_model(f3, alt, mregs[rs1], sign12(imm));
    add_entry(name, i_type(imm, rs1, f3, rd, OPC_OP_IMM), rd != '0, rd, r, 1'b1, 1'b0, '0, 1'b0);
    set_reg(rd, r);
  endtask

  task automatic upper_imm(input string name, input logic [6:0] opc, input reg_idx_t rd,
                           input logic [19:0] imm);
    word_t r;
    r = {imm, 12'b0};
    if (opc == OPC_AUIPC)
      r = pc_next + r;
    add_entry(name, {imm, rd, opc}, rd != '0, rd, r, 1'b1, 1'b0, '0, 1'b0);
    set_reg(rd, r);
  endtask

  task automatic load_const(input reg_idx_t rd, input word_t v);
    word_t hi;
    hi = v + 32'h0000_0800; // Cancels the ADDI sign extension
    upper_imm("lui", OPC_LUI, rd, hi[31:12]);
    imm_op("addi", F3_ADD, rd, rd, v[11:0]);
  endtask

  task automatic branch_op(input string name, input funct3_t f3, input reg_idx_t rs1,
                           input reg_idx_t rs2, input logic [12:0] off);
    logic tk;
    tk = branch_model(f3, mregs[rs1], mregs[rs2]);
    add_entry(name, b_type(off, rs2, rs1, f3), 1'b0, '0, '0, 1'b0, tk,
              pc_next + {{19{off[12]}}, off}, 1'b1);
  endtask

  task automatic store_word(input reg_idx_t rs1, input reg_idx_t rs2, input logic [11:0] imm);
    add_entry("sw", s_type(imm, rs2, rs1), 1'b0, '0, mregs[rs1] + sign12(imm), 1'b1,
              1'b0, '0, 1'b0);
  endtask

  task automatic jump_link(input reg_idx_t rd, input logic [20:0] off);
    word_t link;
    link = pc_next + 32'd4;
    add_entry("jal", j_type(off, rd), rd != '0, rd, link, 1'b1, 1'b1,
              pc_next + {{11{off[20]}}, off}, 1'b1);
    set_reg(rd, link);
  endtask

  task automatic jump_reg(input reg_idx_t rd, input reg_idx_t rs1, input logic [11:0] imm);
    word_t link;
    word_t tgt;
    link = pc_next + 32'd4;
    tgt  = (mregs[rs1] + sign12(imm)) & 32'hffff_fffe; // Bit 0 dropped
    add_entry("jalr", i_type(imm, rs1, 3'd0, rd, OPC_JALR), rd != '0, rd, link, 1'b1, 1'b1,
              tgt, 1'b1);
    set_reg(rd, link);
  endtask

  task automatic build_table();
    word_t r;
    for (int i = 0; i < 32; i++)
      mregs[i] = '0;
    pc_next = 32'h0000_1000;
    load_const(5'd1, next_rand());
    load_const(5'd2, next_rand());
    load_const(5'd3, 32'h8765_4321); // Negative operand for SRA
    reg_op("add", F3_ADD, 1'b0, 5'd5, 5'd1, 5'd2);
    reg_op("sub", F3_ADD, 1'b1, 5'd6, 5'd1, 5'd2);
    reg_op("sll", F3_SLL, 1'b0, 5'd7, 5'd1, 5'd2);
    reg_op("slt", F3_SLT, 1'b0, 5'd8, 5'd3, 5'd1);
    reg_op("sltu", F3_SLTU, 1'b0, 5'd9, 5'd3, 5'd1);
    reg_op("xor", F3_XOR, 1'b0, 5'd10, 5'd1, 5'd2);
    reg_op("srl", F3_SR, 1'b0, 5'd11, 5'd3, 5'd2);
    reg_op("sra", F3_SR, 1'b1, 5'd12, 5'd3, 5'd2);
    reg_op("or", F3_OR, 1'b0, 5'd13, 5'd1, 5'd2);
    reg_op("and", F3_AND, 1'b0, 5'd14, 5'd1, 5'd2);
    r = next_rand();
    imm_op("addi", F3_ADD, 5'd15, 5'd1, r[11:0]);
    imm_op("slti", F3_SLT, 5'd16, 5'd3, 12'h005);
    imm_op("sltiu", F3_SLTU, 5'd17, 5'd1, 12'hfff);
    imm_op("xori", F3_XOR, 5'd18, 5'd2, r[23:12]);
    r = next_rand();
    imm_op("ori", F3_OR, 5'd19, 5'd1, r[11:0]);
    imm_op("andi", F3_AND, 5'd20, 5'd2, r[23:12]);
    imm_op("slli", F3_SLL, 5'd21, 5'd1, {7'b0, r[28:24]});
    imm_op("srli", F3_SR, 5'd22, 5'd3, {7'b0, r[28:24]});
    imm_op("srai", F3_SR, 5'd23, 5'd3, {7'b0100000, r[28:24]});
    imm_op("addi", F3_ADD, 5'd24, 5'd1, 12'h123); // Chain at distances 1 to 3
    reg_op("add", F3_ADD, 1'b0, 5'd25, 5'd24, 5'd24);
    reg_op("sub", F3_ADD, 1'b1, 5'd26, 5'd25, 5'd24);
    reg_op("xor", F3_XOR, 1'b0, 5'd27, 5'd26, 5'd24);
    reg_op("add", F3_ADD, 1'b0, 5'd28, 5'd27, 5'd26);
    branch_op("beq", 3'd0, 5'd1, 5'd1, 13'h0010);
    branch_op("beq", 3'd0, 5'd1, 5'd2, 13'h0010);
    branch_op("bne", 3'd1, 5'd1, 5'd1, 13'h1ff0);
    branch_op("blt", 3'd4, 5'd3, 5'd1, 13'h0ffe);
    branch_op("bge", 3'd5, 5'd3, 5'd1, 13'h1000);
    branch_op("bltu", 3'd6, 5'd3, 5'd1, 13'h0024);
    branch_op("bgeu", 3'd7, 5'd3, 5'd1, 13'h1f80);
    store_word(5'd1, 5'd2, 12'h7fc);
    upper_imm("lui", OPC_LUI, 5'd29, r[31:12]);
    upper_imm("auipc", OPC_AUIPC, 5'd30, 20'hfffff);
    jump_link(5'd31, 21'h000100);
    jump_link(5'd0, 21'h1ffff0); // Taken but writes nothing
    imm_op("addi", F3_ADD, 5'd5, 5'd0, 12'h0a5); // Odd base for JALR
    jump_reg(5'd6, 5'd5, 12'h00c);
    imm_op("addi", F3_ADD, 5'd0, 5'd1, 12'h055); // Dropped write to x0
    upper_imm("lui", OPC_LUI, 5'd0, 20'h12345);
    reg_op("add", F3_ADD, 1'b0, 5'd7, 5'd0, 5'd0);
    reg_op("or", F3_OR, 1'b0, 5'd8, 5'd0, 5'd1);
  endtask

  task automatic compare_word(input string sig, input word_t got, input word_t exp);
    if (got !== exp)
    begin
      $display("Fail %s in %s: got 0x%h, expected 0x%h", sig, cur_name, got, exp);
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_idx(input string sig, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp)
    begin
      $display("Fail %s in %s: got 0x%h, expected 0x%h", sig, cur_name, got, exp);
      test_bad = 1'b1;
    end
  endtask

  task automatic compare_bit(input string sig, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("Fail %s in %s: got 0x%h, expected 0x%h", sig, cur_name, got, exp);
      test_bad = 1'b1;
    end
  endtask

  task automatic check_entry(input int t_issue);
    entry_t e;
    e        = tbl[chk_idx];
    cur_name = tbl_name[chk_idx];
    test_bad = 1'b0;
    if (ncyc != t_issue + 3) // Driven to visible is three cycles
    begin
      $display("Result of %s came %0d cycles after issue instead of 3", cur_name,
               ncyc - t_issue);
      test_bad = 1'b1;
    end
    compare_bit("o_wr_en", res_wr_en, e.wr);
    if (e.wr)
      compare_idx("o_rd", res_rd, e.rd);
    if (e.chk_res)
      compare_word("o_result", result, e.res);
    compare_bit("o_branch_taken", taken, e.tk);
    if (e.chk_tgt)
      compare_word("o_target", target, e.tgt);
    $display("test %0d %s at pc 0x%h: %s", chk_idx, cur_name, e.pc, test_bad ? "error" : "ok");
    if (test_bad)
      fail_cnt++;
    else
      pass_cnt++;
    chk_idx++;
  endtask

  // Outputs sampled at the falling edge between drive edges
  always @(negedge clk)
  begin
    ncyc = ncyc + 1;
    if (rst === 1'b0)
    begin
      if (res_valid === 1'b1)
      begin
        if (issue_q.size() == 0)
        begin
          $display("Result strobe seen with no instruction in flight");
          fail_cnt++;
        end
        else
          check_entry(issue_q.pop_front());
      end
      else if (res_valid !== 1'b0)
      begin
        $display("Result strobe is unknown after reset");
        fail_cnt++;
      end
      if (valid === 1'b1)
        issue_q.push_back(ncyc);
    end
  end

  initial
  begin
    valid    <= 1'b0;
    instr    <= '0;
    pc       <= '0;
    rng      = 32'h0450_3fde;
    ncyc     = 0;
    chk_idx  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();
    wait_cnt = 0;
    while (rst !== 1'b0 && wait_cnt < 20) // Reset release
    begin
      @(posedge clk);
      wait_cnt++;
    end
    repeat (4) @(posedge clk); // Idle gap with no result expected
    for (int i = 0; i < tbl.size(); i++)
    begin
      @(posedge clk);
      valid <= 1'b1;
      instr <= tbl[i].instr;
      pc    <= tbl[i].pc;
    end
    @(posedge clk);
    valid <= 1'b0;
    wait_cnt = 0;
    while (chk_idx < tbl.size() && wait_cnt < 50) // Drain the pipeline
    begin
      @(posedge clk);
      wait_cnt++;
    end
    if (chk_idx < tbl.size())
    begin
      $display("Timeout with %0d results still missing", tbl.size() - chk_idx);
      $display("** FAIL **");
      $finish;
    end
    else
    begin
      repeat (4) @(posedge clk); // Latency checks see the idle tail
      $display("%0d tests passed, %0d failures, %0d assertion failures", pass_cnt, fail_cnt,
               uut.u_chk.err_cnt);
      if (fail_cnt == 0 && uut.u_chk.err_cnt == 0)
        $display("** PASS **");
      else
        $display("** FAIL **");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_operand.sv
hw/rv_alu.sv
hw/rv_exec_core.sv
verif/rv_clkgen.sv
verif/rv_exec_chk.sv
verif/rv_exec_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP      := rv_exec_tb
FILELIST := sim.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SRCS     := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -qF '** FAIL **' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
